//--- rtl/fwd_pkg.sv
`default_nettype none

package fwd_pkg;

	// ====================
	// Widths and tap counts
	localparam int REG_ADDR_W = 7; // 128 registers.
	localparam int DATA_W     = 128;
	localparam int UNIT_ID_W  = 4;
	localparam int EVEN_TAPS  = 6; // Stages 3..7 and write-back.
	localparam int ODD_TAPS   = 5; // Stages 4..7 and write-back.

	// ====================
	// Opcodes and producing units
	typedef enum logic [7:0] {
		NOP_EXEC      = 8'h01,
		NOP_LOAD      = 8'h02,
		ADD_WORD      = 8'h10, // Even pipe.
		SUB_WORD      = 8'h11,
		AND_WORD      = 8'h12,
		SHIFT_LEFT    = 8'h13,
		COUNT_ONES    = 8'h14,
		FP_ADD        = 8'h20,
		FP_MUL_DOUBLE = 8'h21,
		LOAD_QUAD     = 8'h40, // Odd pipe.
		STORE_QUAD    = 8'h41,
		SHUFFLE_BYTES = 8'h50,
		ROTATE_QUAD   = 8'h51,
		BRANCH_REL    = 8'h60
	} opcode_e;

	typedef enum logic [UNIT_ID_W-1:0] {
		UNIT_NONE    = 4'd0,
		UNIT_FX1     = 4'd1,
		UNIT_FX2     = 4'd2,
		UNIT_FP      = 4'd3,
		UNIT_FP_LONG = 4'd4,
		UNIT_BYTE    = 4'd5,
		UNIT_PERM    = 4'd6,
		UNIT_LS      = 4'd7,
		UNIT_BRANCH  = 4'd8
	} unit_id_e;

	// ====================
	// Result readiness by tap
	function automatic logic even_tap_ready(input int tap, input unit_id_e uid);
		logic short_ok;
		logic ready;
		short_ok = (uid == UNIT_FX1) || (uid == UNIT_FX2) || (uid == UNIT_BYTE);
		case (tap)
			0:       ready = (uid == UNIT_FX1); // Stage 3.
			1, 2, 3: ready = short_ok;
			4:       ready = short_ok || (uid == UNIT_FP);
			5:       ready = short_ok || (uid == UNIT_FP) || (uid == UNIT_FP_LONG);
			default: ready = 1'b0;
		endcase
		return ready;
	endfunction

	function automatic logic odd_tap_ready(input int tap, input unit_id_e uid);
		logic ready;
		case (tap)
			0, 1, 2: ready = (uid == UNIT_PERM); // Loads land at stage 7.
			3, 4:    ready = (uid == UNIT_PERM) || (uid == UNIT_LS);
			default: ready = 1'b0;
		endcase
		return ready;
	endfunction

endpackage

`default_nettype wire

//--- rtl/issue_latch.sv
`default_nettype none

module issue_latch #(
	parameter fwd_pkg::opcode_e NOP_OPCODE = fwd_pkg::NOP_EXEC
) (
	input  wire                            clock,
	input  wire                            rst_n,
	input  wire                            flush,

	input  wire fwd_pkg::opcode_e          opcode,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]  ra_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]  rb_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]  rc_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]  rt_addr,
	input  wire                            wr_en_rt,

	output fwd_pkg::opcode_e               opcode_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0] ra_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0] rb_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0] rc_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0] rt_addr_q,
	output logic                           wr_en_rt_q
);

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			opcode_q   <= NOP_OPCODE;
			ra_addr_q  <= '0;
			rb_addr_q  <= '0;
			rc_addr_q  <= '0;
			rt_addr_q  <= '0;
			wr_en_rt_q <= 1'b0;
		end else if (flush) begin
			opcode_q   <= NOP_OPCODE; // Squash to the slot's no-op.
			ra_addr_q  <= '0;
			rb_addr_q  <= '0;
			rc_addr_q  <= '0;
			rt_addr_q  <= '0;
			wr_en_rt_q <= 1'b0;
		end else begin
			opcode_q   <= opcode;
			ra_addr_q  <= ra_addr;
			rb_addr_q  <= rb_addr;
			rc_addr_q  <= rc_addr;
			rt_addr_q  <= rt_addr;
			wr_en_rt_q <= wr_en_rt;
		end
	end

	// ====================
	// A flushed slot must never write its target.
	flush_kills_write: assert property (
		@(posedge clock) disable iff (!rst_n)
		flush |=> !wr_en_rt_q
	) else $error("issue_latch: wr_en_rt_q high in the cycle after flush");

endmodule

`default_nettype wire

//--- rtl/fwd_tap_qualify.sv
`default_nettype none

module fwd_tap_qualify (
	input  wire fwd_pkg::unit_id_e [fwd_pkg::EVEN_TAPS-1:0] even_tap_uid,
	input  wire [fwd_pkg::EVEN_TAPS-1:0]                    even_tap_wr_en,
	input  wire fwd_pkg::unit_id_e [fwd_pkg::ODD_TAPS-1:0]  odd_tap_uid,
	input  wire [fwd_pkg::ODD_TAPS-1:0]                     odd_tap_wr_en,

	output logic [fwd_pkg::EVEN_TAPS-1:0]                   even_live,
	output logic [fwd_pkg::ODD_TAPS-1:0]                    odd_live
);

	// ====================
	// Even pipe, index 0 is stage 3.
	always_comb begin
		for (int i = 0; i < fwd_pkg::EVEN_TAPS; i++) begin
			even_live[i] = even_tap_wr_en[i] &&
				fwd_pkg::even_tap_ready(i, even_tap_uid[i]);
		end
	end

	// ====================
	// Odd pipe, index 0 is stage 4.
	always_comb begin
		for (int i = 0; i < fwd_pkg::ODD_TAPS; i++) begin
			odd_live[i] = odd_tap_wr_en[i] &&
				fwd_pkg::odd_tap_ready(i, odd_tap_uid[i]);
		end
	end

	// An empty slot in the pipe carries no result to forward.
	always_comb begin
		for (int i = 0; i < fwd_pkg::EVEN_TAPS; i++) begin
			even_none_dead: assert (!(even_live[i] &&
				(even_tap_uid[i] == fwd_pkg::UNIT_NONE)))
				else $error("fwd_tap_qualify: even tap %0d live with UNIT_NONE", i);
		end
		for (int i = 0; i < fwd_pkg::ODD_TAPS; i++) begin
			odd_none_dead: assert (!(odd_live[i] &&
				(odd_tap_uid[i] == fwd_pkg::UNIT_NONE)))
				else $error("fwd_tap_qualify: odd tap %0d live with UNIT_NONE", i);
		end
	end

endmodule

`default_nettype wire

//--- rtl/operand_bypass_mux.sv
`default_nettype none

module operand_bypass_mux #(
	parameter int DATA_W = fwd_pkg::DATA_W
) (
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         src_addr,

	input  wire [fwd_pkg::EVEN_TAPS-1:0]                          even_live,
	input  wire [fwd_pkg::ODD_TAPS-1:0]                           odd_live,
	input  wire [fwd_pkg::EVEN_TAPS-1:0][fwd_pkg::REG_ADDR_W-1:0] even_tap_addr,
	input  wire [fwd_pkg::ODD_TAPS-1:0][fwd_pkg::REG_ADDR_W-1:0]  odd_tap_addr,
	input  wire [fwd_pkg::EVEN_TAPS-1:0][DATA_W-1:0]              even_tap_data,
	input  wire [fwd_pkg::ODD_TAPS-1:0][DATA_W-1:0]               odd_tap_data,
	input  wire [DATA_W-1:0]                                      rf_data,

	output logic [DATA_W-1:0]                                     operand
);

	logic [fwd_pkg::EVEN_TAPS-1:0] even_hit;
	logic [fwd_pkg::ODD_TAPS-1:0]  odd_hit;

	// Address compare only, eligibility comes in with the live bits.
	always_comb begin
		for (int i = 0; i < fwd_pkg::EVEN_TAPS; i++) begin
			even_hit[i] = even_live[i] && (even_tap_addr[i] == src_addr);
		end
		for (int i = 0; i < fwd_pkg::ODD_TAPS; i++) begin
			odd_hit[i] = odd_live[i] && (odd_tap_addr[i] == src_addr);
		end
	end

	// ====================
	// Walk from lowest priority up so the last hit taken wins.
	// Order is rf, odd oldest..youngest, even oldest..youngest.
	always_comb begin
		operand = rf_data;
		for (int i = fwd_pkg::ODD_TAPS - 1; i >= 0; i--) begin
			if (odd_hit[i]) begin
				operand = odd_tap_data[i];
			end
		end
		for (int i = fwd_pkg::EVEN_TAPS - 1; i >= 0; i--) begin
			if (even_hit[i]) begin
				operand = even_tap_data[i]; // Youngest even result overrides all.
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/reg_fetch_forward.sv
`default_nettype none

module reg_fetch_forward #(
	parameter int DATA_W = fwd_pkg::DATA_W
) (
	input  wire                                                   clock,
	input  wire                                                   rst_n,
	input  wire                                                   flush,

	// Even slot in.
	input  wire fwd_pkg::opcode_e                                 even_opcode,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         even_ra_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         even_rb_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         even_rc_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         even_rt_addr,
	input  wire                                                   even_wr_en_rt,

	// Odd slot in.
	input  wire fwd_pkg::opcode_e                                 odd_opcode,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         odd_ra_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         odd_rb_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         odd_rc_addr,
	input  wire [fwd_pkg::REG_ADDR_W-1:0]                         odd_rt_addr,
	input  wire                                                   odd_wr_en_rt,

	input  wire [DATA_W-1:0]                                      even_ra_rf_data,
	input  wire [DATA_W-1:0]                                      even_rb_rf_data,
	input  wire [DATA_W-1:0]                                      even_rc_rf_data,
	input  wire [DATA_W-1:0]                                      odd_ra_rf_data,
	input  wire [DATA_W-1:0]                                      odd_rb_rf_data,
	input  wire [DATA_W-1:0]                                      odd_rc_rf_data,

	// In-flight results, youngest first.
	input  wire [fwd_pkg::EVEN_TAPS-1:0][fwd_pkg::REG_ADDR_W-1:0] even_tap_addr,
	input  wire [fwd_pkg::EVEN_TAPS-1:0][DATA_W-1:0]              even_tap_data,
	input  wire fwd_pkg::unit_id_e [fwd_pkg::EVEN_TAPS-1:0]       even_tap_uid,
	input  wire [fwd_pkg::EVEN_TAPS-1:0]                          even_tap_wr_en,
	input  wire [fwd_pkg::ODD_TAPS-1:0][fwd_pkg::REG_ADDR_W-1:0]  odd_tap_addr,
	input  wire [fwd_pkg::ODD_TAPS-1:0][DATA_W-1:0]               odd_tap_data,
	input  wire fwd_pkg::unit_id_e [fwd_pkg::ODD_TAPS-1:0]        odd_tap_uid,
	input  wire [fwd_pkg::ODD_TAPS-1:0]                           odd_tap_wr_en,

	output fwd_pkg::opcode_e                                      even_opcode_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0]                        even_ra_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0]                        even_rb_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0]                        even_rc_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0]                        even_rt_addr_q,
	output logic                                                  even_wr_en_rt_q,
	output fwd_pkg::opcode_e                                      odd_opcode_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0]                        odd_ra_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0]                        odd_rb_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0]                        odd_rc_addr_q,
	output logic [fwd_pkg::REG_ADDR_W-1:0]                        odd_rt_addr_q,
	output logic                                                  odd_wr_en_rt_q,

	output logic [DATA_W-1:0]                                     even_ra_data,
	output logic [DATA_W-1:0]                                     even_rb_data,
	output logic [DATA_W-1:0]                                     even_rc_data,
	output logic [DATA_W-1:0]                                     odd_ra_data,
	output logic [DATA_W-1:0]                                     odd_rb_data,
	output logic [DATA_W-1:0]                                     odd_rc_data
);

	logic [fwd_pkg::EVEN_TAPS-1:0] even_live;
	logic [fwd_pkg::ODD_TAPS-1:0]  odd_live;

	// ====================
	// Issue slots
	issue_latch #(.NOP_OPCODE(fwd_pkg::NOP_EXEC)) even_latch (
		.clock(clock), .rst_n(rst_n), .flush(flush),
		.opcode(even_opcode), .ra_addr(even_ra_addr), .rb_addr(even_rb_addr),
		.rc_addr(even_rc_addr), .rt_addr(even_rt_addr), .wr_en_rt(even_wr_en_rt),
		.opcode_q(even_opcode_q), .ra_addr_q(even_ra_addr_q), .rb_addr_q(even_rb_addr_q),
		.rc_addr_q(even_rc_addr_q), .rt_addr_q(even_rt_addr_q),
		.wr_en_rt_q(even_wr_en_rt_q)
	);

	issue_latch #(.NOP_OPCODE(fwd_pkg::NOP_LOAD)) odd_latch (
		.clock(clock), .rst_n(rst_n), .flush(flush),
		.opcode(odd_opcode), .ra_addr(odd_ra_addr), .rb_addr(odd_rb_addr),
		.rc_addr(odd_rc_addr), .rt_addr(odd_rt_addr), .wr_en_rt(odd_wr_en_rt),
		.opcode_q(odd_opcode_q), .ra_addr_q(odd_ra_addr_q), .rb_addr_q(odd_rb_addr_q),
		.rc_addr_q(odd_rc_addr_q), .rt_addr_q(odd_rt_addr_q),
		.wr_en_rt_q(odd_wr_en_rt_q)
	);

	// ====================
	// Tap eligibility, shared by all six selections.
	fwd_tap_qualify qualify (
		.even_tap_uid(even_tap_uid), .even_tap_wr_en(even_tap_wr_en),
		.odd_tap_uid(odd_tap_uid), .odd_tap_wr_en(odd_tap_wr_en),
		.even_live(even_live), .odd_live(odd_live)
	);

	// ====================
	// Operand bypass
	operand_bypass_mux #(.DATA_W(DATA_W)) even_ra_mux (
		.src_addr(even_ra_addr_q), .even_live(even_live), .odd_live(odd_live),
		.even_tap_addr(even_tap_addr), .odd_tap_addr(odd_tap_addr),
		.even_tap_data(even_tap_data), .odd_tap_data(odd_tap_data),
		.rf_data(even_ra_rf_data), .operand(even_ra_data)
	);

	operand_bypass_mux #(.DATA_W(DATA_W)) even_rb_mux (
		.src_addr(even_rb_addr_q), .even_live(even_live), .odd_live(odd_live),
		.even_tap_addr(even_tap_addr), .odd_tap_addr(odd_tap_addr),
		.even_tap_data(even_tap_data), .odd_tap_data(odd_tap_data),
		.rf_data(even_rb_rf_data), .operand(even_rb_data)
	);

	operand_bypass_mux #(.DATA_W(DATA_W)) even_rc_mux (
		.src_addr(even_rc_addr_q), .even_live(even_live), .odd_live(odd_live),
		.even_tap_addr(even_tap_addr), .odd_tap_addr(odd_tap_addr),
		.even_tap_data(even_tap_data), .odd_tap_data(odd_tap_data),
		.rf_data(even_rc_rf_data), .operand(even_rc_data)
	);

	// Odd side sees the same taps, even write-back included.
	operand_bypass_mux #(.DATA_W(DATA_W)) odd_ra_mux (
		.src_addr(odd_ra_addr_q), .even_live(even_live), .odd_live(odd_live),
		.even_tap_addr(even_tap_addr), .odd_tap_addr(odd_tap_addr),
		.even_tap_data(even_tap_data), .odd_tap_data(odd_tap_data),
		.rf_data(odd_ra_rf_data), .operand(odd_ra_data)
	);

	operand_bypass_mux #(.DATA_W(DATA_W)) odd_rb_mux (
		.src_addr(odd_rb_addr_q), .even_live(even_live), .odd_live(odd_live),
		.even_tap_addr(even_tap_addr), .odd_tap_addr(odd_tap_addr),
		.even_tap_data(even_tap_data), .odd_tap_data(odd_tap_data),
		.rf_data(odd_rb_rf_data), .operand(odd_rb_data)
	);

	operand_bypass_mux #(.DATA_W(DATA_W)) odd_rc_mux (
		.src_addr(odd_rc_addr_q), .even_live(even_live), .odd_live(odd_live),
		.even_tap_addr(even_tap_addr), .odd_tap_addr(odd_tap_addr),
		.even_tap_data(even_tap_data), .odd_tap_data(odd_tap_data),
		.rf_data(odd_rc_rf_data), .operand(odd_rc_data)
	);

endmodule

`default_nettype wire

//--- testbench/rf_fwd_model.svh
`ifndef RF_FWD_MODEL_SVH
`define RF_FWD_MODEL_SVH

// ====================
// Latched slot state
fwd_pkg::opcode_e  exp_even_opcode;
logic [ADDR_W-1:0] exp_even_ra;
logic [ADDR_W-1:0] exp_even_rb;
logic [ADDR_W-1:0] exp_even_rc;
logic [ADDR_W-1:0] exp_even_rt;
logic              exp_even_we;
fwd_pkg::opcode_e  exp_odd_opcode;
logic [ADDR_W-1:0] exp_odd_ra;
logic [ADDR_W-1:0] exp_odd_rb;
logic [ADDR_W-1:0] exp_odd_rc;
logic [ADDR_W-1:0] exp_odd_rt;
logic              exp_odd_we;

// Both slots become their no-op with cleared fields.
task automatic load_no_ops();
	exp_even_opcode = fwd_pkg::NOP_EXEC;
	exp_even_ra     = '0;
	exp_even_rb     = '0;
	exp_even_rc     = '0;
	exp_even_rt     = '0;
	exp_even_we     = 1'b0;
	exp_odd_opcode  = fwd_pkg::NOP_LOAD;
	exp_odd_ra      = '0;
	exp_odd_rb      = '0;
	exp_odd_rc      = '0;
	exp_odd_rt      = '0;
	exp_odd_we      = 1'b0;
endtask

// State after the next rising edge, from the inputs now driven.
task automatic model_update();
	if (flush) begin
		load_no_ops();
	end else begin
		exp_even_opcode = even_opcode;
		exp_even_ra     = even_ra_addr;
		exp_even_rb     = even_rb_addr;
		exp_even_rc     = even_rc_addr;
		exp_even_rt     = even_rt_addr;
		exp_even_we     = even_wr_en_rt;
		exp_odd_opcode  = odd_opcode;
		exp_odd_ra      = odd_ra_addr;
		exp_odd_rb      = odd_rb_addr;
		exp_odd_rc      = odd_rc_addr;
		exp_odd_rt      = odd_rt_addr;
		exp_odd_we      = odd_wr_en_rt;
	end
endtask

// ====================
// Forwarding rule
// First eligible match, even youngest to oldest, then odd youngest to oldest.
function automatic logic [DATA_W-1:0] expected_operand(input logic [ADDR_W-1:0] src,
		input logic [DATA_W-1:0] rf);
	logic [DATA_W-1:0] result;
	logic              found;
	result = rf;
	found  = 1'b0;
	for (int i = 0; i < fwd_pkg::EVEN_TAPS; i++) begin
		if (!found && even_tap_wr_en[i] && (even_tap_addr[i] == src) &&
				fwd_pkg::even_tap_ready(i, even_tap_uid[i])) begin
			result = even_tap_data[i];
			found  = 1'b1;
		end
	end
	for (int i = 0; i < fwd_pkg::ODD_TAPS; i++) begin
		if (!found && odd_tap_wr_en[i] && (odd_tap_addr[i] == src) &&
				fwd_pkg::odd_tap_ready(i, odd_tap_uid[i])) begin
			result = odd_tap_data[i];
			found  = 1'b1;
		end
	end
	return result;
endfunction

`endif

//--- testbench/tb_reg_fetch_forward.sv
`default_nettype none

module tb_reg_fetch_forward;

	localparam int ADDR_W          = fwd_pkg::REG_ADDR_W;
	localparam int DATA_W          = fwd_pkg::DATA_W;
	localparam int RESET_CYCLES    = 3;
	localparam int RANDOM_CYCLES   = 400;
	localparam int DIRECTED_CYCLES = 10;
	localparam int WATCHDOG_TIME   = (RESET_CYCLES + RANDOM_CYCLES + DIRECTED_CYCLES) * 4 * 2;

	logic clock;
	logic rst_n;
	logic flush;
	fwd_pkg::opcode_e even_opcode, odd_opcode, even_opcode_q, odd_opcode_q;
	logic [ADDR_W-1:0] even_ra_addr, even_rb_addr, even_rc_addr, even_rt_addr;
	logic [ADDR_W-1:0] odd_ra_addr, odd_rb_addr, odd_rc_addr, odd_rt_addr;
	logic [ADDR_W-1:0] even_ra_addr_q, even_rb_addr_q, even_rc_addr_q, even_rt_addr_q;
	logic [ADDR_W-1:0] odd_ra_addr_q, odd_rb_addr_q, odd_rc_addr_q, odd_rt_addr_q;
	logic even_wr_en_rt, odd_wr_en_rt, even_wr_en_rt_q, odd_wr_en_rt_q;
	logic [DATA_W-1:0] even_ra_rf_data, even_rb_rf_data, even_rc_rf_data;
	logic [DATA_W-1:0] odd_ra_rf_data, odd_rb_rf_data, odd_rc_rf_data;
	logic [DATA_W-1:0] even_ra_data, even_rb_data, even_rc_data;
	logic [DATA_W-1:0] odd_ra_data, odd_rb_data, odd_rc_data;
	logic [fwd_pkg::EVEN_TAPS-1:0][ADDR_W-1:0] even_tap_addr;
	logic [fwd_pkg::EVEN_TAPS-1:0][DATA_W-1:0] even_tap_data;
	fwd_pkg::unit_id_e [fwd_pkg::EVEN_TAPS-1:0] even_tap_uid;
	logic [fwd_pkg::EVEN_TAPS-1:0]             even_tap_wr_en;
	logic [fwd_pkg::ODD_TAPS-1:0][ADDR_W-1:0]  odd_tap_addr;
	logic [fwd_pkg::ODD_TAPS-1:0][DATA_W-1:0]  odd_tap_data;
	fwd_pkg::unit_id_e [fwd_pkg::ODD_TAPS-1:0]  odd_tap_uid;
	logic [fwd_pkg::ODD_TAPS-1:0]              odd_tap_wr_en;

	integer seed = 32'h4999;
	int checks = 0;
	int errors = 0;
	int mark_checks = 0;
	int mark_errors = 0;

	`include "rf_fwd_model.svh"

	reg_fetch_forward #(.DATA_W(DATA_W)) DUT (.*);

	always #2 clock = ~clock;

	// ====================
	// Stimulus helpers
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic logic [DATA_W-1:0] random_data();
		logic [DATA_W-1:0] d;
		for (int k = 0; k < DATA_W / 32; k++) begin
			d[k*32 +: 32] = $random(seed);
		end
		return d;
	endfunction

	function automatic fwd_pkg::opcode_e random_opcode();
		case (rand_below(8))
			0:       return fwd_pkg::ADD_WORD;
			1:       return fwd_pkg::FP_ADD;
			2:       return fwd_pkg::FP_MUL_DOUBLE;
			3:       return fwd_pkg::LOAD_QUAD;
			4:       return fwd_pkg::SHUFFLE_BYTES;
			5:       return fwd_pkg::BRANCH_REL;
			6:       return fwd_pkg::NOP_LOAD;
			default: return fwd_pkg::NOP_EXEC;
		endcase
	endfunction

	task automatic drive_random_inputs(input logic allow_flush);
		flush         = allow_flush && (rand_below(16) == 0); // Rare.
		even_opcode   = random_opcode();
		odd_opcode    = random_opcode();
		even_ra_addr  = ADDR_W'(rand_below(8)); // Small range so matches are common.
		even_rb_addr  = ADDR_W'(rand_below(8));
		even_rc_addr  = ADDR_W'(rand_below(8));
		even_rt_addr  = ADDR_W'(rand_below(8));
		odd_ra_addr   = ADDR_W'(rand_below(8));
		odd_rb_addr   = ADDR_W'(rand_below(8));
		odd_rc_addr   = ADDR_W'(rand_below(8));
		odd_rt_addr   = ADDR_W'(rand_below(8));
		even_wr_en_rt = 1'(rand_below(2));
		odd_wr_en_rt  = 1'(rand_below(2));
		even_ra_rf_data = random_data();
		even_rb_rf_data = random_data();
		even_rc_rf_data = random_data();
		odd_ra_rf_data  = random_data();
		odd_rb_rf_data  = random_data();
		odd_rc_rf_data  = random_data();
		for (int i = 0; i < fwd_pkg::EVEN_TAPS; i++) begin
			even_tap_addr[i]  = ADDR_W'(rand_below(8));
			even_tap_data[i]  = random_data();
			even_tap_uid[i]   = fwd_pkg::unit_id_e'(4'(rand_below(9)));
			even_tap_wr_en[i] = 1'(rand_below(2));
		end
		for (int i = 0; i < fwd_pkg::ODD_TAPS; i++) begin
			odd_tap_addr[i]  = ADDR_W'(rand_below(8));
			odd_tap_data[i]  = random_data();
			odd_tap_uid[i]   = fwd_pkg::unit_id_e'(4'(rand_below(9)));
			odd_tap_wr_en[i] = 1'(rand_below(2));
		end
	endtask

	task automatic set_sources(input logic [ADDR_W-1:0] addr);
		even_ra_addr = addr;
		even_rb_addr = addr;
		even_rc_addr = addr;
		odd_ra_addr  = addr;
		odd_rb_addr  = addr;
		odd_rc_addr  = addr;
	endtask

	task automatic set_taps(input logic [ADDR_W-1:0] addr, input fwd_pkg::unit_id_e e_uid,
			input fwd_pkg::unit_id_e o_uid, input logic [fwd_pkg::EVEN_TAPS-1:0] e_we,
			input logic [fwd_pkg::ODD_TAPS-1:0] o_we);
		for (int i = 0; i < fwd_pkg::EVEN_TAPS; i++) begin
			even_tap_addr[i] = addr;
			even_tap_uid[i]  = e_uid;
		end
		for (int i = 0; i < fwd_pkg::ODD_TAPS; i++) begin
			odd_tap_addr[i] = addr;
			odd_tap_uid[i]  = o_uid;
		end
		even_tap_wr_en = e_we;
		odd_tap_wr_en  = o_we;
	endtask

	// ====================
	// Checking
	task automatic compare_value(input string name, input logic [DATA_W-1:0] actual,
			input logic [DATA_W-1:0] expected);
		checks++;
		assert (actual === expected) else begin
			$display("CHECK FAILED time %0t signal %s expected %0h actual %0h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic verify_outputs();
		compare_value("even_opcode_q", DATA_W'(even_opcode_q), DATA_W'(exp_even_opcode));
		compare_value("even_ra_addr_q", DATA_W'(even_ra_addr_q), DATA_W'(exp_even_ra));
		compare_value("even_rb_addr_q", DATA_W'(even_rb_addr_q), DATA_W'(exp_even_rb));
		compare_value("even_rc_addr_q", DATA_W'(even_rc_addr_q), DATA_W'(exp_even_rc));
		compare_value("even_rt_addr_q", DATA_W'(even_rt_addr_q), DATA_W'(exp_even_rt));
		compare_value("even_wr_en_rt_q", DATA_W'(even_wr_en_rt_q), DATA_W'(exp_even_we));
		compare_value("odd_opcode_q", DATA_W'(odd_opcode_q), DATA_W'(exp_odd_opcode));
		compare_value("odd_ra_addr_q", DATA_W'(odd_ra_addr_q), DATA_W'(exp_odd_ra));
		compare_value("odd_rb_addr_q", DATA_W'(odd_rb_addr_q), DATA_W'(exp_odd_rb));
		compare_value("odd_rc_addr_q", DATA_W'(odd_rc_addr_q), DATA_W'(exp_odd_rc));
		compare_value("odd_rt_addr_q", DATA_W'(odd_rt_addr_q), DATA_W'(exp_odd_rt));
		compare_value("odd_wr_en_rt_q", DATA_W'(odd_wr_en_rt_q), DATA_W'(exp_odd_we));
		compare_value("even_ra_data", even_ra_data, expected_operand(exp_even_ra, even_ra_rf_data));
		compare_value("even_rb_data", even_rb_data, expected_operand(exp_even_rb, even_rb_rf_data));
		compare_value("even_rc_data", even_rc_data, expected_operand(exp_even_rc, even_rc_rf_data));
		compare_value("odd_ra_data", odd_ra_data, expected_operand(exp_odd_ra, odd_ra_rf_data));
		compare_value("odd_rb_data", odd_rb_data, expected_operand(exp_odd_rb, odd_rb_rf_data));
		compare_value("odd_rc_data", odd_rc_data, expected_operand(exp_odd_rc, odd_rc_rf_data));
	endtask

	task automatic begin_cycle(input logic allow_flush);
		@(negedge clock);
		drive_random_inputs(allow_flush);
	endtask

	task automatic end_cycle();
		#1; // Just before the rising edge.
		verify_outputs();
		model_update();
	endtask

	task automatic report_test(input string name);
		$display("test %-16s %0d checks, %0d mismatches", name,
			checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	// ====================
	// Test sequence
	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		drive_random_inputs(1'b0);
		load_no_ops();
		repeat (RESET_CYCLES) @(posedge clock);

		begin_cycle(1'b0);
		rst_n = 1'b1;
		end_cycle();
		report_test("reset_values");

		repeat (RANDOM_CYCLES) begin
			begin_cycle(1'b1);
			end_cycle();
		end
		report_test("random_traffic");

		begin_cycle(1'b0);
		flush = 1'b1;
		end_cycle();
		begin_cycle(1'b0);
		end_cycle();
		report_test("flush_to_nop");

		begin_cycle(1'b0);
		set_sources(ADDR_W'(3));
		end_cycle();
		begin_cycle(1'b0);
		set_sources(ADDR_W'(3));
		set_taps(ADDR_W'(3), fwd_pkg::UNIT_FX1, fwd_pkg::UNIT_PERM, '1, '1);
		end_cycle();
		compare_value("even_ra_data", even_ra_data, even_tap_data[0]); // Youngest even.
		compare_value("odd_rc_data", odd_rc_data, even_tap_data[0]);
		begin_cycle(1'b0);
		set_sources(ADDR_W'(3));
		set_taps(ADDR_W'(3), fwd_pkg::UNIT_FX1, fwd_pkg::UNIT_PERM, '0, '1);
		end_cycle();
		compare_value("even_rb_data", even_rb_data, odd_tap_data[0]); // Youngest odd.
		compare_value("odd_ra_data", odd_ra_data, odd_tap_data[0]);
		report_test("priority_order");

		begin_cycle(1'b0);
		set_sources(ADDR_W'(3));
		end_cycle();
		begin_cycle(1'b0);
		set_sources(ADDR_W'(3));
		set_taps(ADDR_W'(3), fwd_pkg::UNIT_FX1, fwd_pkg::UNIT_PERM, '0, '0);
		even_tap_wr_en[1] = 1'b1;
		even_tap_uid[1]   = fwd_pkg::UNIT_FP; // Not done at stage 4.
		odd_tap_wr_en[0]  = 1'b1;
		odd_tap_uid[0]    = fwd_pkg::UNIT_LS; // Not done at stage 4.
		end_cycle();
		compare_value("even_ra_data", even_ra_data, even_ra_rf_data);
		compare_value("odd_ra_data", odd_ra_data, odd_ra_rf_data);
		report_test("skip_not_ready");

		begin_cycle(1'b0);
		set_sources(ADDR_W'(5));
		end_cycle();
		begin_cycle(1'b0);
		set_sources(ADDR_W'(5));
		set_taps(ADDR_W'(5), fwd_pkg::UNIT_FP_LONG, fwd_pkg::UNIT_BRANCH, '1, '1);
		odd_tap_uid[4] = fwd_pkg::UNIT_LS;
		end_cycle();
		compare_value("even_ra_data", even_ra_data, even_tap_data[5]);
		compare_value("even_rb_data", even_rb_data, even_tap_data[5]);
		compare_value("even_rc_data", even_rc_data, even_tap_data[5]);
		compare_value("odd_ra_data", odd_ra_data, even_tap_data[5]);
		compare_value("odd_rb_data", odd_rb_data, even_tap_data[5]);
		compare_value("odd_rc_data", odd_rc_data, even_tap_data[5]);
		report_test("writeback_order");

		$display("tests 6, checks %0d, mismatches %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Timeout, the tests did not finish within %0d time units", WATCHDOG_TIME);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+testbench
rtl/fwd_pkg.sv
rtl/issue_latch.sv
rtl/fwd_tap_qualify.sv
rtl/operand_bypass_mux.sv
rtl/reg_fetch_forward.sv
testbench/tb_reg_fetch_forward.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the register-fetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --top-module tb_reg_fetch_forward -f all.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_reg_fetch_forward > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$log"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $log"
	exit 1
fi
